//--- source/nes_pad_pkg.sv
/* Controller port definitions
   Port and pad counts, pad button layout, shift word views,
   multitap signatures and configuration bit positions */
`default_nettype none

package nes_pad_pkg;

	localparam int NUM_PORTS  = 2;  // Console controller ports
	localparam int NUM_PADS   = 4;  // Host pads A to D
	localparam int PAD_BITS   = 8;
	localparam int SHIFT_BITS = 24;

	// Host order: 0 right, 1 left, 2 down, 3 up, 4 A, 5 B, 6 select, 7 start
	// Console order: 0 A, 1 B, 2 select, 3 start, 4 up, 5 down, 6 left, 7 right
	typedef logic [PAD_BITS-1:0] pad_t;

	// Standard read, one pad then all-ones fill
	typedef struct packed {
		logic [SHIFT_BITS-PAD_BITS-1:0] fill;
		pad_t                           pad;
	} shift_std_t;

	// Four-player adapter read
	typedef struct packed {
		logic [PAD_BITS-1:0] sig;     // Adapter signature, shifted out last
		pad_t                second;
		pad_t                first;   // Shifted out first
	} shift_tap_t;

	typedef union packed {
		shift_std_t std_view;
		shift_tap_t tap_view;
	} pad_shift_u;

	localparam logic [PAD_BITS-1:0] SIG_PORT0 = 8'h08;
	localparam logic [PAD_BITS-1:0] SIG_PORT1 = 8'h04;

	// Configuration word bits
	localparam int CFG_SWAP_BIT     = 0;
	localparam int CFG_MULTITAP_BIT = 1;
	localparam int CFG_MIC_BIT      = 2;

endpackage

`default_nettype wire

//--- source/pad_bus_pkg.sv
/* Host bus definitions
   Wishbone widths and register map */
`default_nettype none

package pad_bus_pkg;

	localparam int WB_ADDR_BITS = 3;
	localparam int WB_DATA_BITS = 8;

	// Register map, other addresses read zero
	localparam logic [WB_ADDR_BITS-1:0] REG_CFG   = 3'd0;
	localparam logic [WB_ADDR_BITS-1:0] REG_PAD_A = 3'd1;
	localparam logic [WB_ADDR_BITS-1:0] REG_PAD_B = 3'd2;
	localparam logic [WB_ADDR_BITS-1:0] REG_PAD_C = 3'd3;
	localparam logic [WB_ADDR_BITS-1:0] REG_PAD_D = 3'd4;

endpackage

`default_nettype wire

//--- source/pad_cfg_if.sv
/* Configuration and pad state link
   Register block to mapper and output stage */
`default_nettype none
`timescale 1ns/1ns

interface pad_cfg_if;
	import nes_pad_pkg::*;

	logic swap;        // Exchange pads A and B
	logic multitap;    // Four-player adapter mode
	logic mic_button;
	pad_t pads [NUM_PADS];  // Host order

	modport regs (output swap, multitap, mic_button, pads);

	modport mapper (input swap, multitap, pads);

	modport drive (input mic_button);

endinterface

`default_nettype wire

//--- source/pad_regs.sv
/* Host register block
   Wishbone classic slave with the configuration word
   and the four pad state registers */
`default_nettype none
`timescale 1ns/1ns

module pad_regs (
	input  wire                                   clk,
	input  wire                                   reset_nes,
	input  wire                                   wb_cyc,
	input  wire                                   wb_stb,
	input  wire                                   wb_we,
	input  wire  [pad_bus_pkg::WB_ADDR_BITS-1:0]  wb_adr,
	input  wire  [pad_bus_pkg::WB_DATA_BITS-1:0]  wb_wdata,
	output logic [pad_bus_pkg::WB_DATA_BITS-1:0]  wb_rdata,
	output logic                                  wb_ack,
	pad_cfg_if.regs                               cfg
);
	import nes_pad_pkg::*;
	import pad_bus_pkg::*;

	logic                    req;
	logic [WB_DATA_BITS-1:0] cfg_word;
	logic [WB_DATA_BITS-1:0] rd_mux;

	assign req = wb_cyc & wb_stb & ~wb_ack;  // Ack cycle never starts a new access

	//////////////////////////////
	// Read decode
	always_comb begin
		cfg_word = '0;  // Spare bits read back zero
		cfg_word[CFG_SWAP_BIT]     = cfg.swap;
		cfg_word[CFG_MULTITAP_BIT] = cfg.multitap;
		cfg_word[CFG_MIC_BIT]      = cfg.mic_button;
	end

	always_comb begin
		case (wb_adr)
			REG_CFG:   rd_mux = cfg_word;
			REG_PAD_A: rd_mux = cfg.pads[0];
			REG_PAD_B: rd_mux = cfg.pads[1];
			REG_PAD_C: rd_mux = cfg.pads[2];
			REG_PAD_D: rd_mux = cfg.pads[3];
			default:   rd_mux = '0;
		endcase
	end

	//////////////////////////////
	// Write and ack
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wb_ack         <= 1'b0;
			wb_rdata       <= '0;
			cfg.swap       <= 1'b0;
			cfg.multitap   <= 1'b0;
			cfg.mic_button <= 1'b0;
			for (int i = 0; i < NUM_PADS; i++)
				cfg.pads[i] <= '0;
		end else begin
			wb_ack <= req;  // Single cycle ack
			if (req)
				wb_rdata <= rd_mux;
			if (req && wb_we) begin
				case (wb_adr)
					REG_CFG: begin
						cfg.swap       <= wb_wdata[CFG_SWAP_BIT];
						cfg.multitap   <= wb_wdata[CFG_MULTITAP_BIT];
						cfg.mic_button <= wb_wdata[CFG_MIC_BIT];
					end
					REG_PAD_A: cfg.pads[0] <= wb_wdata;
					REG_PAD_B: cfg.pads[1] <= wb_wdata;
					REG_PAD_C: cfg.pads[2] <= wb_wdata;
					REG_PAD_D: cfg.pads[3] <= wb_wdata;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pad_mapper.sv
/* Pad to port mapper
   Console button reorder, port swap, standard and multitap
   load word assembly, registered per port */
`default_nettype none
`timescale 1ns/1ns

module pad_mapper (
	input  wire                       clk,
	input  wire                       reset_nes,
	pad_cfg_if.mapper                 cfg,
	output nes_pad_pkg::pad_shift_u   load_word [nes_pad_pkg::NUM_PORTS]
);
	import nes_pad_pkg::*;

	localparam pad_t SIG_BYTE [NUM_PORTS] = '{SIG_PORT0, SIG_PORT1};

	pad_t       con_pad    [NUM_PADS];
	pad_t       first_pad  [NUM_PORTS];
	pad_t       second_pad [NUM_PORTS];
	pad_shift_u next_word  [NUM_PORTS];

	// Host order into console shift order, A ends up in bit 0
	function automatic pad_t to_console(input pad_t host);
		return {host[0], host[1], host[2], host[3], host[7], host[6], host[5], host[4]};
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++)
			con_pad[i] = to_console(cfg.pads[i]);
	end

	// Swap touches A and B only
	assign first_pad[0]  = cfg.swap ? con_pad[1] : con_pad[0];
	assign first_pad[1]  = cfg.swap ? con_pad[0] : con_pad[1];
	assign second_pad[0] = con_pad[2];  // Pad C behind port 0
	assign second_pad[1] = con_pad[3];  // Pad D behind port 1

	//////////////////////////////
	// Load word assembly
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (cfg.multitap) begin
				next_word[p].tap_view.sig    = SIG_BYTE[p];
				next_word[p].tap_view.second = second_pad[p];
				next_word[p].tap_view.first  = first_pad[p];
			end else begin
				next_word[p].std_view.fill = '1;  // Idle lines read as ones
				next_word[p].std_view.pad  = first_pad[p];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int p = 0; p < NUM_PORTS; p++)
				load_word[p] <= '0;
		end else begin
			load_word <= next_word;
		end
	end

endmodule

`default_nettype wire

//--- source/port_shifter.sv
/* Controller port shift register
   Parallel load on strobe, right shift on port clock fall */
`default_nettype none
`timescale 1ns/1ns

module port_shifter (
	input  wire                      clk,
	input  wire                      reset_nes,
	input  wire                      strobe,
	input  wire                      port_clock,
	input  wire nes_pad_pkg::pad_shift_u load_word,
	output logic                     data_bit
);
	import nes_pad_pkg::*;

	logic [SHIFT_BITS-1:0] shift_reg;
	logic                  clock_prev;  // Last port clock sample
	logic                  clock_fall;

	assign clock_fall = clock_prev & ~port_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_reg  <= '0;
			clock_prev <= 1'b0;
		end else begin
			clock_prev <= port_clock;
			if (strobe)
				shift_reg <= load_word;  // Strobe wins over a shift
			else if (clock_fall)
				shift_reg <= {1'b0, shift_reg[SHIFT_BITS-1:1]};
		end
	end

	assign data_bit = shift_reg[0];

endmodule

`default_nettype wire

//--- source/pad_data_drive.sv
/* Console side output stage
   Port data bus and the microphone pulse generator */
`default_nettype none
`timescale 1ns/1ns

module pad_data_drive #(
	parameter int MIC_PERIOD = 251,
	parameter int MIC_HIGH   = 215
) (
	input  wire                                  clk,
	input  wire                                  reset_nes,
	pad_cfg_if.drive                             cfg,
	input  wire  [nes_pad_pkg::NUM_PORTS-1:0]    data_bit,
	output logic [nes_pad_pkg::NUM_PORTS-1:0]    joypad_data,
	output logic                                 mic
);

	localparam int                  CNT_BITS = $clog2(MIC_PERIOD);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(MIC_PERIOD - 1);
	localparam logic [CNT_BITS-1:0] CNT_HIGH = CNT_BITS'(MIC_HIGH);

	logic [CNT_BITS-1:0] mic_cnt;

	// Port bit 0 goes straight to the data lines
	assign joypad_data = data_bit;

	// Free running duty counter
	always_ff @(posedge clk) begin
		if (reset_nes)
			mic_cnt <= '0;
		else if (mic_cnt == CNT_LAST)
			mic_cnt <= '0;
		else
			mic_cnt <= mic_cnt + 1'b1;
	end

	assign mic = (mic_cnt < CNT_HIGH) && cfg.mic_button;  // Held button gives a pulse train

endmodule

`default_nettype wire

//--- source/nes_pad_top.sv
/* Controller port top level
   Host registers, mapper, one shifter per port, output stage */
`default_nettype none
`timescale 1ns/1ns

module nes_pad_top #(
	parameter int MIC_PERIOD = 251,
	parameter int MIC_HIGH   = 215
) (
	input  wire                                  clk,
	input  wire                                  reset_nes,
	// Host bus
	input  wire                                  wb_cyc,
	input  wire                                  wb_stb,
	input  wire                                  wb_we,
	input  wire  [pad_bus_pkg::WB_ADDR_BITS-1:0] wb_adr,
	input  wire  [pad_bus_pkg::WB_DATA_BITS-1:0] wb_wdata,
	output logic [pad_bus_pkg::WB_DATA_BITS-1:0] wb_rdata,
	output logic                                 wb_ack,
	// Console side
	input  wire                                  joypad_strobe,
	input  wire  [nes_pad_pkg::NUM_PORTS-1:0]    joypad_clock,
	output logic [nes_pad_pkg::NUM_PORTS-1:0]    joypad_data,
	output logic                                 mic
);
	import nes_pad_pkg::*;

	pad_cfg_if cfg_bus ();

	pad_shift_u           load_word [NUM_PORTS];
	logic [NUM_PORTS-1:0] port_bit;

	pad_regs u_regs (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_wdata  (wb_wdata),
		.wb_rdata  (wb_rdata),
		.wb_ack    (wb_ack),
		.cfg       (cfg_bus.regs)
	);

	pad_mapper u_mapper (
		.clk       (clk),
		.reset_nes (reset_nes),
		.cfg       (cfg_bus.mapper),
		.load_word (load_word)
	);

	//////////////////////////////
	// One shifter per console port
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		port_shifter u_shifter (
			.clk        (clk),
			.reset_nes  (reset_nes),
			.strobe     (joypad_strobe),    // Shared by both ports
			.port_clock (joypad_clock[i]),
			.load_word  (load_word[i]),
			.data_bit   (port_bit[i])
		);
	end

	pad_data_drive #(
		.MIC_PERIOD (MIC_PERIOD),
		.MIC_HIGH   (MIC_HIGH)
	) u_drive (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.cfg         (cfg_bus.drive),
		.data_bit    (port_bit),
		.joypad_data (joypad_data),
		.mic         (mic)
	);

endmodule

`default_nettype wire

//--- verification/tb_pad_model.svh
/* Testbench reference model
   Xorshift generator, host to console pad order
   and expected port load words */
`ifndef TB_PAD_MODEL_SVH
`define TB_PAD_MODEL_SVH

logic [31:0] rng_state;

// 32-bit xorshift, state kept across calls
function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// Console bit n comes from host bit host_src[n]
function automatic logic [7:0] to_console_order(input logic [7:0] host);
	int         host_src [8];
	logic [7:0] con;
	host_src = '{4, 5, 6, 7, 3, 2, 1, 0};
	for (int n = 0; n < 8; n++)
		con[n] = host[host_src[n]];
	return con;
endfunction

// Pads in host order, result is the word as loaded on strobe
function automatic logic [23:0] expected_port_word(input int port, input logic tap,
		input logic swp, input logic [7:0] pad_a, pad_b, pad_c, pad_d);
	logic [7:0] first;
	logic [7:0] second;
	logic [7:0] sig;
	first  = (port == 0) ? (swp ? pad_b : pad_a) : (swp ? pad_a : pad_b);
	second = (port == 0) ? pad_c : pad_d;
	sig    = (port == 0) ? 8'h08 : 8'h04;
	if (tap)
		return {sig, to_console_order(second), to_console_order(first)};
	return {16'hffff, to_console_order(first)};
endfunction

`endif

//--- verification/tb_nes_pad.sv
/* Controller port testbench
   Register, standard, multitap, swap and mic checks
   against a reference model, with a cycle limit */
`default_nettype none
`timescale 1ns/1ns

module tb_nes_pad;

	localparam int SEED          = 23520;
	localparam int REG_TESTS     = 40;
	localparam int STD_TESTS     = 30;
	localparam int TAP_TESTS     = 30;
	localparam int MIC_PERIOD    = 251;
	localparam int MIC_HIGH      = 215;
	localparam int ACCESS_CYCLES = 4;  // Request, ack, idle
	localparam int READ_CYCLES   = 5 * ACCESS_CYCLES + 5 + 26 * 3;
	localparam int CYCLE_LIMIT   = 2 * (8 + (2 * REG_TESTS + 3) * ACCESS_CYCLES
		+ (STD_TESTS + TAP_TESTS + 2) * READ_CYCLES + 2 * (MIC_PERIOD + ACCESS_CYCLES));

	`include "tb_pad_model.svh"

	logic       clk = 1'b0;
	logic       reset_nes;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [2:0] wb_adr;
	logic [7:0] wb_wdata;
	logic [7:0] wb_rdata;
	logic       wb_ack;
	logic       joypad_strobe;
	logic [1:0] joypad_clock;
	logic [1:0] joypad_data;
	logic       mic;

	logic [7:0] model_regs [8];  // Addresses 5 to 7 stay zero
	int         errors;
	int         checks;
	int         cycle_count;

	always #4 clk = ~clk;

	nes_pad_top #(
		.MIC_PERIOD (MIC_PERIOD),
		.MIC_HIGH   (MIC_HIGH)
	) u_dut (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_wdata      (wb_wdata),
		.wb_rdata      (wb_rdata),
		.wb_ack        (wb_ack),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data),
		.mic           (mic)
	);

	//////////////////////////////
	// Checks and bus access
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_wdata <= wdata;
		@(negedge clk);
		check_true(wb_ack === 1'b0, "Ack came in the same cycle as the request");
		@(negedge clk);
		check_true(wb_ack === 1'b1, "Ack did not come one cycle after the request");
		rdata = wb_rdata;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		check_true(wb_ack === 1'b0, "Ack stayed high for more than one cycle");
	endtask

	task automatic reg_write(input logic [2:0] adr, input logic [7:0] data);
		logic [7:0] unused;
		wb_access(1'b1, adr, data, unused);
		if (adr == 3'd0)
			model_regs[0] = data & 8'h07;  // Swap, multitap, mic only
		else if (adr <= 3'd4)
			model_regs[adr] = data;
	endtask

	task automatic reg_check(input logic [2:0] adr);
		logic [7:0] rd;
		wb_access(1'b0, adr, 8'h00, rd);
		check_value($sformatf("readback addr %0d", adr), model_regs[adr], rd);
	endtask

	//////////////////////////////
	// Port reads and mic window
	task automatic port_test(input string name, input logic tap, input logic swp);
		logic [31:0] r;
		logic [25:0] stream0;
		logic [25:0] stream1;
		logic [23:0] word0;
		logic [23:0] word1;
		reg_write(3'd0, {6'b0, tap, swp});
		for (int i = 1; i <= 4; i++) begin
			r = next_random();
			reg_write(3'(i), r[7:0]);
		end
		word0 = expected_port_word(0, tap, swp, model_regs[1], model_regs[2],
			model_regs[3], model_regs[4]);
		word1 = expected_port_word(1, tap, swp, model_regs[1], model_regs[2],
			model_regs[3], model_regs[4]);
		repeat (3) @(posedge clk);  // Mapper settles
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		for (int i = 0; i < 26; i++) begin
			@(negedge clk);
			stream0[i] = joypad_data[0];
			stream1[i] = joypad_data[1];
			@(posedge clk);
			joypad_clock <= 2'b11;
			@(posedge clk);
			joypad_clock <= 2'b00;
			@(posedge clk);  // Shift lands here
		end
		check_value({name, " port 0"}, {2'b00, word0}, stream0);
		check_value({name, " port 1"}, {2'b00, word1}, stream1);
	endtask

	task automatic mic_test(input string name, input logic button, input int expected_high);
		int high_count;
		reg_write(3'd0, {5'b0, button, 2'b00});
		high_count = 0;
		repeat (MIC_PERIOD) begin
			@(negedge clk);
			if (mic === 1'b1)
				high_count++;
		end
		check_value(name, expected_high, high_count);
	endtask

	// Cycle limit
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d errors so far", cycle_count, errors);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0] r;
		rng_state     = SEED;
		errors        = 0;
		checks        = 0;
		reset_nes     = 1'b1;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = 3'd0;
		wb_wdata      = 8'h00;
		joypad_strobe = 1'b0;
		joypad_clock  = 2'b00;
		for (int a = 0; a < 8; a++)
			model_regs[a] = 8'h00;
		repeat (4) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check_value("reset wb_ack", 0, wb_ack);
		check_value("reset joypad_data", 0, joypad_data);
		check_value("reset mic", 0, mic);

		for (int t = 0; t < REG_TESTS; t++) begin
			r = next_random();
			reg_write(r[2:0], r[15:8]);
			reg_check(r[2:0]);
		end
		for (int a = 5; a < 8; a++)
			reg_check(3'(a));

		for (int t = 0; t < STD_TESTS; t++) begin
			r = next_random();
			port_test("standard", 1'b0, r[0]);
		end
		for (int t = 0; t < TAP_TESTS; t++) begin
			r = next_random();
			port_test("multitap", 1'b1, r[0]);
		end
		port_test("swap standard", 1'b0, 1'b1);
		port_test("swap multitap", 1'b1, 1'b1);

		mic_test("mic duty with button", 1'b1, MIC_HIGH);
		mic_test("mic with button clear", 1'b0, 0);

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
source/nes_pad_pkg.sv
source/pad_bus_pkg.sv
source/pad_cfg_if.sv
source/pad_regs.sv
source/pad_mapper.sv
source/port_shifter.sv
source/pad_data_drive.sv
source/nes_pad_top.sv
verification/tb_nes_pad.sv
